// File: rtl/dmem_config.svh
//////////////////////////////////////////////////
// Build-time constants for the data memory interface
// Region map and bus depth, included where needed
//////////////////////////////////////////////////

`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// Address and data width
`define DMEM_ADDR_W 32

// Region 0, main memory, not bufferable
`define DMEM_R0_BASE 32'h0000_0000
`define DMEM_R0_END 32'h0000_FFFF

// Region 1, peripheral space, bufferable
`define DMEM_R1_BASE 32'h1000_0000
`define DMEM_R1_END 32'h1000_FFFF

// Bus transactions in flight
`define DMEM_OUTST_DEPTH 2

`endif

// File: rtl/dmem_pkg.sv
//////////////////////////////////////////////////
// Shared types for the data memory interface
// Import inside module bodies, scoped names in ports
//////////////////////////////////////////////////

`include "dmem_config.svh"

package dmem_pkg;

  // Memory type bits
  // Bit 0 bufferable, bit 1 cacheable
  typedef logic [1:0] memtype_t;

  localparam int MEMTYPE_BUF_BIT = 0;
  localparam int MEMTYPE_CACHE_BIT = 1;

  //////////////////////////////////////////////////
  // Bus request
  //////////////////////////////////////////////////

  // One data request as it goes out on the bus
  typedef struct packed {
    logic [`DMEM_ADDR_W-1:0] addr;
    logic we;
    logic [3:0] be;
    logic [`DMEM_ADDR_W-1:0] wdata;
    memtype_t memtype;
  } obi_data_req_t;

  //////////////////////////////////////////////////
  // Write buffer and bus tracking
  //////////////////////////////////////////////////

  // Write buffer holds at most one word
  typedef enum logic {
    WBUF_EMPTY,
    WBUF_FULL
  } wbuf_state_e;

  // One issued bus transaction
  // Drop set when the LSU response went out early
  typedef struct packed {
    logic drop;
  } outst_t;

endpackage

// File: rtl/dmem_req_if.sv
//////////////////////////////////////////////////
// Checked LSU request between PMA and control
// Valid/ready handshake with fault flag
//////////////////////////////////////////////////

`timescale 1ns/100ps

interface dmem_req_if ();
  import dmem_pkg::*;

  // Request is on offer
  logic valid;
  // Control block takes it this cycle
  logic ready;
  // Request with its memory type
  obi_data_req_t trans;
  // Address hits no region
  logic fault;

  // PMA side
  modport source (
    output valid, trans, fault,
    input ready
  );

  // Control side
  modport sink (
    input valid, trans, fault,
    output ready
  );

endinterface

// File: rtl/dmem_pma.sv
//////////////////////////////////////////////////
// Fixed region lookup for LSU data requests
// Sets memory type, flags accesses outside all regions
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "dmem_config.svh"

module dmem_pma (
  dmem_req_if.source pma_o,
  input logic lsu_valid_i,
  input logic [`DMEM_ADDR_W-1:0] lsu_addr_i,
  input logic [`DMEM_ADDR_W-1:0] lsu_wdata_i,
  input logic lsu_we_i,
  input logic [3:0] lsu_be_i
);
  import dmem_pkg::*;

  logic r0_hit;
  logic r1_hit;
  memtype_t memtype;

  //////////////////////////////////////////////////
  // Region match
  //////////////////////////////////////////////////

  // Main memory
  assign r0_hit = (lsu_addr_i >= `DMEM_R0_BASE) && (lsu_addr_i <= `DMEM_R0_END);
  // Peripheral space
  assign r1_hit = (lsu_addr_i >= `DMEM_R1_BASE) && (lsu_addr_i <= `DMEM_R1_END);

  // Memory type per region
  always_comb begin
    memtype = '0;
    if (r0_hit) begin
      // Main memory may be cached, never buffered
      memtype[MEMTYPE_CACHE_BIT] = 1'b1;
    end else if (r1_hit) begin
      // Only writes are buffered, reads must wait for data
      memtype[MEMTYPE_BUF_BIT] = lsu_we_i;
    end
  end

  //////////////////////////////////////////////////
  // Checked request
  //////////////////////////////////////////////////

  assign pma_o.valid = lsu_valid_i;
  // Fault only for a live request
  assign pma_o.fault = lsu_valid_i && !(r0_hit || r1_hit);

  assign pma_o.trans.addr = lsu_addr_i;
  assign pma_o.trans.we = lsu_we_i;
  assign pma_o.trans.be = lsu_be_i;
  assign pma_o.trans.wdata = lsu_wdata_i;
  assign pma_o.trans.memtype = memtype;

endmodule

// File: rtl/dmem_write_buffer.sv
//////////////////////////////////////////////////
// One-word write buffer in front of the data bus
// Stores bufferable writes while the bus stalls
//////////////////////////////////////////////////

`timescale 1ns/100ps

module dmem_write_buffer (
  input logic clk,
  input logic rst_n,

  // Upstream side, from control
  input logic valid_i,
  input dmem_pkg::obi_data_req_t trans_i,
  output logic ready_o,

  // Downstream side, to the bus
  output logic valid_o,
  output dmem_pkg::obi_data_req_t trans_o,
  input logic ready_i
);
  import dmem_pkg::*;

  wbuf_state_e state_q;
  wbuf_state_e state_d;
  obi_data_req_t buf_q;
  logic push;
  logic bufferable;

  // Write to a bufferable region
  assign bufferable = trans_i.memtype[MEMTYPE_BUF_BIT];

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    push = 1'b0;
    case (state_q)
      WBUF_EMPTY: begin
        // Bus stalls, park the write
        if (valid_i && bufferable && !ready_i) begin
          push = 1'b1;
          state_d = WBUF_FULL;
        end
      end
      WBUF_FULL: begin
        if (ready_i) begin
          // Stored word leaves, a new write can take its place
          push = valid_i && bufferable;
          state_d = push ? WBUF_FULL : WBUF_EMPTY;
        end
      end
      default: state_d = WBUF_EMPTY;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WBUF_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Stored word
  always_ff @(posedge clk) begin
    if (push) begin
      buf_q <= trans_i;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Stored word goes out ahead of anything new
  assign valid_o = (state_q == WBUF_FULL) || valid_i;
  assign trans_o = (state_q == WBUF_FULL) ? buf_q : trans_i;

  // Full: only a write that refills the freed slot
  // Empty: any write, or anything the bus takes now
  assign ready_o = (state_q == WBUF_FULL) ? (bufferable && ready_i) :
                                            (bufferable || ready_i);

endmodule

// File: rtl/dmem_outstanding_fifo.sv
//////////////////////////////////////////////////
// Tracks issued bus transactions in grant order
// One entry per grant, popped on each bus response
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "dmem_config.svh"

module dmem_outstanding_fifo (
  input logic clk,
  input logic rst_n,
  input logic push_i,
  input logic pop_i,
  input dmem_pkg::outst_t entry_i,
  output dmem_pkg::outst_t entry_o,
  output logic full_o,
  output logic empty_o,
  output logic live_o
);
  import dmem_pkg::*;

  localparam int DEPTH = `DMEM_OUTST_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  outst_t mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  // Entries without drop flag
  logic [CNT_W-1:0] live_cnt_q;
  logic do_push;
  logic do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop = pop_i && !empty_o;

  // Wrap a pointer at the end of storage
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q <= '0;
      live_cnt_q <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
      live_cnt_q <= live_cnt_q + CNT_W'(do_push && !entry_i.drop)
                               - CNT_W'(do_pop && !entry_o.drop);
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= entry_i;
  end

  assign entry_o = mem_q[rd_ptr_q];
  assign full_o = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign live_o = (live_cnt_q != '0);

endmodule

// File: rtl/dmem_ctrl.sv
//////////////////////////////////////////////////
// Request acceptance and response steering
// Early responses for buffered writes and faults
//////////////////////////////////////////////////

`timescale 1ns/100ps

module dmem_ctrl (
  input logic clk,
  input logic rst_n,

  // Checked LSU request
  dmem_req_if.sink pma_i,

  // Write buffer
  output logic wb_valid_o,
  output dmem_pkg::obi_data_req_t wb_trans_o,
  input logic wb_ready_i,
  input logic wb_valid_i,
  input dmem_pkg::obi_data_req_t wb_trans_i,
  output logic wb_gnt_o,

  // Bus handshake and response
  input logic obi_gnt_i,
  input logic obi_rvalid_i,
  input logic obi_err_i,
  input logic [31:0] obi_rdata_i,
  output logic obi_req_o,

  // LSU response
  output logic lsu_resp_valid_o,
  output logic lsu_resp_err_o,
  output logic [31:0] lsu_resp_rdata_o
);
  import dmem_pkg::*;

  outst_t fifo_in;
  outst_t fifo_out;
  logic fifo_full;
  logic fifo_empty;
  logic fifo_live;
  logic bufferable;
  logic can_accept;
  logic accept;
  logic imm_valid_q;
  logic imm_err_q;

  //////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////

  assign bufferable = pma_i.trans.memtype[MEMTYPE_BUF_BIT];

  // Early responses wait until no bus response can still reach the LSU
  always_comb begin
    if (pma_i.fault) begin
      can_accept = !fifo_live;
    end else if (bufferable) begin
      can_accept = wb_ready_i && !fifo_live;
    end else begin
      // Granted in this very cycle
      can_accept = wb_ready_i;
    end
  end

  assign accept = pma_i.valid && can_accept;
  assign pma_i.ready = accept;

  // Faults never go near the buffer or bus
  assign wb_valid_o = pma_i.valid && !pma_i.fault && (!bufferable || !fifo_live);
  assign wb_trans_o = pma_i.trans;

  //////////////////////////////////////////////////
  // Bus gating and tracking
  //////////////////////////////////////////////////

  // No issue while tracking is full
  assign obi_req_o = wb_valid_i && !fifo_full;
  assign wb_gnt_o = obi_gnt_i && !fifo_full;

  // Response of a buffered write is thrown away later
  assign fifo_in.drop = wb_trans_i.we && wb_trans_i.memtype[MEMTYPE_BUF_BIT];

  dmem_outstanding_fifo outst_fifo_i (
    .clk(clk),
    .rst_n(rst_n),
    .push_i(obi_req_o && obi_gnt_i),
    .pop_i(obi_rvalid_i && !fifo_empty),
    .entry_i(fifo_in),
    .entry_o(fifo_out),
    .full_o(fifo_full),
    .empty_o(fifo_empty),
    .live_o(fifo_live)
  );

  //////////////////////////////////////////////////
  // LSU response
  //////////////////////////////////////////////////

  // Early response one cycle after acceptance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      imm_valid_q <= 1'b0;
      imm_err_q <= 1'b0;
    end else begin
      imm_valid_q <= accept && (pma_i.fault || bufferable);
      imm_err_q <= pma_i.fault;
    end
  end

  // Bus responses pass unless marked for drop
  assign lsu_resp_valid_o = imm_valid_q || (obi_rvalid_i && !fifo_out.drop);
  assign lsu_resp_err_o = imm_valid_q ? imm_err_q : obi_err_i;
  assign lsu_resp_rdata_o = obi_rdata_i;

endmodule

// File: rtl/dmem_top.sv
//////////////////////////////////////////////////
// Data memory interface top level
// LSU requests in, OBI data bus out
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "dmem_config.svh"

module dmem_top (
  input logic clk,
  input logic rst_n,

  // LSU request
  input logic lsu_req_valid_i,
  input logic [`DMEM_ADDR_W-1:0] lsu_req_addr_i,
  input logic lsu_req_we_i,
  input logic [3:0] lsu_req_be_i,
  input logic [`DMEM_ADDR_W-1:0] lsu_req_wdata_i,
  output logic lsu_req_ready_o,

  // LSU response
  output logic lsu_resp_valid_o,
  output logic [31:0] lsu_resp_rdata_o,
  output logic lsu_resp_err_o,

  // OBI data bus
  output logic obi_req_o,
  input logic obi_gnt_i,
  output logic [`DMEM_ADDR_W-1:0] obi_addr_o,
  output logic obi_we_o,
  output logic [3:0] obi_be_o,
  output logic [`DMEM_ADDR_W-1:0] obi_wdata_o,
  output logic [1:0] obi_memtype_o,
  input logic obi_rvalid_i,
  input logic [31:0] obi_rdata_i,
  input logic obi_err_i
);
  import dmem_pkg::*;

  obi_data_req_t wb_in;
  obi_data_req_t wb_out;
  logic wb_valid_in;
  logic wb_ready;
  logic wb_valid_out;
  logic wb_gnt;

  dmem_req_if req_if ();

  dmem_pma pma_i (
    .pma_o(req_if.source),
    .lsu_valid_i(lsu_req_valid_i),
    .lsu_addr_i(lsu_req_addr_i),
    .lsu_wdata_i(lsu_req_wdata_i),
    .lsu_we_i(lsu_req_we_i),
    .lsu_be_i(lsu_req_be_i)
  );

  dmem_ctrl ctrl_i (
    .clk(clk), .rst_n(rst_n), .pma_i(req_if.sink),
    .wb_valid_o(wb_valid_in), .wb_trans_o(wb_in), .wb_ready_i(wb_ready),
    .wb_valid_i(wb_valid_out), .wb_trans_i(wb_out), .wb_gnt_o(wb_gnt),
    .obi_gnt_i(obi_gnt_i), .obi_rvalid_i(obi_rvalid_i), .obi_err_i(obi_err_i),
    .obi_rdata_i(obi_rdata_i), .obi_req_o(obi_req_o),
    .lsu_resp_valid_o(lsu_resp_valid_o), .lsu_resp_err_o(lsu_resp_err_o),
    .lsu_resp_rdata_o(lsu_resp_rdata_o)
  );

  dmem_write_buffer wbuf_i (
    .clk(clk), .rst_n(rst_n),
    .valid_i(wb_valid_in), .trans_i(wb_in), .ready_o(wb_ready),
    .valid_o(wb_valid_out), .trans_o(wb_out), .ready_i(wb_gnt)
  );

  assign lsu_req_ready_o = req_if.ready;

  // Bus fields straight from the buffer output
  assign obi_addr_o = wb_out.addr;
  assign obi_we_o = wb_out.we;
  assign obi_be_o = wb_out.be;
  assign obi_wdata_o = wb_out.wdata;
  assign obi_memtype_o = wb_out.memtype;

endmodule

// File: dv/dmem_sva.sv
//////////////////////////////////////////////////
// Bus protocol and reset checks for the data memory interface
// Bound into every dmem_top instance
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "dmem_config.svh"

module dmem_sva (
  input logic clk,
  input logic rst_n,
  input logic obi_req_i,
  input logic obi_gnt_i,
  input logic [`DMEM_ADDR_W-1:0] obi_addr_i,
  input logic obi_we_i,
  input logic [3:0] obi_be_i,
  input logic [`DMEM_ADDR_W-1:0] obi_wdata_i,
  input logic obi_rvalid_i,
  input logic lsu_req_ready_i,
  input logic lsu_resp_valid_i
);

  // Failed assertions, read by the testbench at the end
  int fail_cnt = 0;
  // Granted bus requests still waiting for rvalid
  int in_flight;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(obi_req_i && obi_gnt_i) - int'(obi_rvalid_i);
    end
  end

  //////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////

  // Request held with all fields until granted
  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (obi_req_i && !obi_gnt_i) |=>
      (obi_req_i && $stable({obi_addr_i, obi_we_i, obi_be_i, obi_wdata_i})))
    else begin
      $error("bus request dropped or changed before its grant");
      fail_cnt++;
    end

  // Never more transactions in flight than the FIFO tracks
  in_flight_a: assert property (@(posedge clk) disable iff (!rst_n)
    (in_flight <= `DMEM_OUTST_DEPTH) && (!obi_req_i || in_flight < `DMEM_OUTST_DEPTH))
    else begin
      $error("too many bus transactions in flight");
      fail_cnt++;
    end

  // Quiet outputs in reset and on the first edge after it
  reset_quiet_a: assert property (@(posedge clk)
    (!rst_n || $rose(rst_n)) |-> (!obi_req_i && !lsu_resp_valid_i && !lsu_req_ready_i))
    else begin
      $error("request or response active during reset");
      fail_cnt++;
    end

endmodule

bind dmem_top dmem_sva sva_i (
  .clk(clk),
  .rst_n(rst_n),
  .obi_req_i(obi_req_o),
  .obi_gnt_i(obi_gnt_i),
  .obi_addr_i(obi_addr_o),
  .obi_we_i(obi_we_o),
  .obi_be_i(obi_be_o),
  .obi_wdata_i(obi_wdata_o),
  .obi_rvalid_i(obi_rvalid_i),
  .lsu_req_ready_i(lsu_req_ready_o),
  .lsu_resp_valid_i(lsu_resp_valid_o)
);

// File: dv/dmem_tb.sv
//////////////////////////////////////////////////
// Testbench for dmem_top with an OBI slave model
// Directed then LFSR requests with a scoreboard on LSU and bus
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "dmem_config.svh"

module dmem_tb;
  localparam int WAIT_LIMIT = 400;
  localparam int RANDOM_REQS = 400;

  // One LSU request and the bus request it should cause
  typedef struct {
    string name;
    logic [31:0] addr;
    logic we;
    logic [3:0] be;
    logic [31:0] wdata;
  } req_t;

  // Expected LSU response or pending bus response
  typedef struct {
    string name;
    logic imm;
    logic err;
    logic [31:0] data;
    logic chk_data;
    int due;
  } exp_t;

  logic clk = 1'b0;
  logic rst_n;
  logic lsu_req_valid_i;
  logic [31:0] lsu_req_addr_i;
  logic lsu_req_we_i;
  logic [3:0] lsu_req_be_i;
  logic [31:0] lsu_req_wdata_i;
  logic lsu_req_ready_o;
  logic lsu_resp_valid_o;
  logic [31:0] lsu_resp_rdata_o;
  logic lsu_resp_err_o;
  logic obi_req_o;
  logic obi_gnt_i;
  logic [31:0] obi_addr_o;
  logic obi_we_o;
  logic [3:0] obi_be_o;
  logic [31:0] obi_wdata_o;
  logic [1:0] obi_memtype_o;
  logic obi_rvalid_i;
  logic [31:0] obi_rdata_i;
  logic obi_err_i;

  logic [31:0] lfsr_q = 32'he3d8bd71;
  int cyc = 0;
  int mismatch_cnt = 0;
  int other_cnt = 0;
  string cur_name = "idle";
  req_t req_q[$];
  req_t bus_exp_q[$];
  exp_t exp_q[$];
  exp_t resp_q[$];
  // Data as the LSU should see it and as the slave holds it
  logic [31:0] ref_mem[logic [31:0]];
  logic [31:0] bus_mem[logic [31:0]];

  dmem_top dmem_top_i (.*);

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return r;
  endfunction

  function automatic logic in_region(input logic [31:0] a);
    return ((a >= `DMEM_R0_BASE) && (a <= `DMEM_R0_END)) ||
           ((a >= `DMEM_R1_BASE) && (a <= `DMEM_R1_END));
  endfunction

  // Main memory is the cacheable region
  function automatic logic in_main(input logic [31:0] a);
    return (a >= `DMEM_R0_BASE) && (a <= `DMEM_R0_END);
  endfunction

  // Writes to peripheral space complete early
  function automatic logic is_buffered(input logic [31:0] a, input logic we);
    return we && (a >= `DMEM_R1_BASE) && (a <= `DMEM_R1_END);
  endfunction

  // Slave errors on the top 4 KB of each region
  function automatic logic is_bad(input logic [31:0] a);
    return a[15:12] == 4'hF;
  endfunction

  // Unwritten words
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [3:0] be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old & ~mask) | (wd & mask);
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s: expected %h, actual %h", test, what, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR at cycle %0d: %s", cyc, msg);
    other_cnt++;
  endtask

  task automatic add_req(input string name, input logic [31:0] addr, input logic we,
                         input logic [3:0] be, input logic [31:0] wdata);
    req_t r;
    r.name = name;
    r.addr = addr;
    r.we = we;
    r.be = be;
    r.wdata = wdata;
    req_q.push_back(r);
  endtask

  task automatic finish_run();
    int sva_fails;
    sva_fails = dmem_top_i.sva_i.fail_cnt;
    $display("Error counts: %0d mismatches, %0d other errors, %0d assertion failures",
             mismatch_cnt, other_cnt, sva_fails);
    if (mismatch_cnt + other_cnt + sva_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////

  task automatic record_accept();
    exp_t e;
    req_t b;
    logic [31:0] a;
    a = lsu_req_addr_i;
    b.name = cur_name;
    b.addr = a;
    b.we = lsu_req_we_i;
    b.be = lsu_req_be_i;
    b.wdata = lsu_req_wdata_i;
    e.name = cur_name;
    e.due = cyc + 1;
    e.data = ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    // Faults answer early with err and never reach the bus
    if (!in_region(a)) begin
      e.imm = 1'b1;
      e.err = 1'b1;
      e.chk_data = 1'b0;
    end else begin
      e.imm = is_buffered(a, lsu_req_we_i);
      e.err = !e.imm && is_bad(a);
      e.chk_data = !lsu_req_we_i && !e.err;
      if (lsu_req_we_i && !is_bad(a)) begin
        ref_mem[a] = merge_bytes(e.data, lsu_req_wdata_i, lsu_req_be_i);
      end
      bus_exp_q.push_back(b);
    end
    exp_q.push_back(e);
  endtask

  // Slave takes the request and answers 1 to 3 cycles later in order
  task automatic record_grant();
    req_t b;
    exp_t r;
    assert (in_region(obi_addr_o)) else report_failure("bus request outside all regions");
    if (bus_exp_q.size() == 0) begin
      report_failure("bus request with no accepted LSU request behind it");
    end else begin
      b = bus_exp_q.pop_front();
      check_value(b.name, "bus addr", b.addr, obi_addr_o);
      check_value(b.name, "bus we", b.we, obi_we_o);
      check_value(b.name, "bus be", b.be, obi_be_o);
      check_value(b.name, "bus wdata", b.wdata, obi_wdata_o);
      check_value(b.name, "bus memtype", {in_main(b.addr), is_buffered(b.addr, b.we)},
                  obi_memtype_o);
    end
    r.err = is_bad(obi_addr_o);
    r.data = bus_mem.exists(obi_addr_o) ? bus_mem[obi_addr_o] : fill_word(obi_addr_o);
    if (obi_we_o && !r.err) begin
      bus_mem[obi_addr_o] = merge_bytes(r.data, obi_wdata_o, obi_be_o);
    end
    r.due = cyc + 1 + int'(rand_bits(2) % 3);
    if (resp_q.size() != 0 && r.due <= resp_q[$].due) begin
      r.due = resp_q[$].due + 1;
    end
    resp_q.push_back(r);
  endtask

  task automatic check_response();
    exp_t e;
    if (exp_q.size() == 0) begin
      report_failure("LSU response with no request waiting for one");
    end else begin
      e = exp_q.pop_front();
      check_value(e.name, "resp err", e.err, lsu_resp_err_o);
      if (e.imm) begin
        check_value(e.name, "resp cycle", e.due, cyc);
      end
      if (e.chk_data) begin
        check_value(e.name, "resp rdata", e.data, lsu_resp_rdata_o);
      end
    end
  endtask

  // Sample on the rising edge with inputs settled since the falling one
  always @(posedge clk) begin
    if (rst_n) begin
      if (lsu_req_valid_i && lsu_req_ready_o) begin
        record_accept();
      end
      if (obi_req_o && obi_gnt_i) begin
        record_grant();
      end
      if (obi_rvalid_i && resp_q.size() != 0) begin
        void'(resp_q.pop_front());
      end
      if (lsu_resp_valid_o) begin
        check_response();
      end else if (exp_q.size() != 0 && exp_q[0].imm && exp_q[0].due == cyc) begin
        report_failure("early LSU response missing one cycle after acceptance");
      end
    end
    cyc++;
  end

  // Slave drives grant and response on the falling edge
  always @(negedge clk) begin
    obi_gnt_i = 1'b0;
    obi_rvalid_i = 1'b0;
    obi_rdata_i = '0;
    obi_err_i = 1'b0;
    if (rst_n) begin
      // Grant three cycles in four
      obi_gnt_i = rand_bits(2) != 0;
      if (resp_q.size() != 0 && cyc >= resp_q[0].due) begin
        obi_rvalid_i = 1'b1;
        obi_rdata_i = resp_q[0].data;
        obi_err_i = resp_q[0].err;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic drive_req(input req_t r, output logic accepted);
    int waited;
    cur_name = r.name;
    lsu_req_valid_i = 1'b1;
    lsu_req_addr_i = r.addr;
    lsu_req_we_i = r.we;
    lsu_req_be_i = r.be;
    lsu_req_wdata_i = r.wdata;
    waited = 0;
    @(posedge clk);
    while (!lsu_req_ready_o && waited < WAIT_LIMIT) begin
      waited++;
      @(posedge clk);
    end
    accepted = lsu_req_ready_o;
    if (!accepted) begin
      report_failure("LSU request never accepted, lsu_req_ready_o stayed low");
    end
    @(negedge clk);
  endtask

  initial begin
    logic [31:0] sel;
    logic [31:0] addr;
    logic we;
    logic [3:0] be;
    logic [31:0] wdata;
    logic accepted;
    int idx;
    int waited;
    rst_n = 1'b0;
    lsu_req_valid_i = 1'b0;
    lsu_req_addr_i = '0;
    lsu_req_we_i = 1'b0;
    lsu_req_be_i = '0;
    lsu_req_wdata_i = '0;
    obi_gnt_i = 1'b0;
    obi_rvalid_i = 1'b0;
    obi_rdata_i = '0;
    obi_err_i = 1'b0;
    // Directed cases first
    add_req("read_r0", 32'h0000_0100, 1'b0, 4'hF, 32'h0);
    add_req("read_r0", 32'h0000_0104, 1'b0, 4'hF, 32'h0);
    add_req("buf_write", 32'h1000_0010, 1'b1, 4'hF, 32'hCAFE_0001);
    add_req("write_read", 32'h1000_0010, 1'b0, 4'hF, 32'h0);
    add_req("buf_write", 32'h1000_0014, 1'b1, 4'h6, 32'h1234_5678);
    add_req("write_read", 32'h1000_0014, 1'b0, 4'hF, 32'h0);
    add_req("fault", 32'h2000_0040, 1'b0, 4'hF, 32'h0);
    add_req("fault", 32'h0001_0000, 1'b1, 4'hF, 32'h0BAD_0BAD);
    add_req("bus_error", 32'h0000_F010, 1'b0, 4'hF, 32'h0);
    add_req("bus_error", 32'h0000_F014, 1'b1, 4'hF, 32'h7777_0000);
    add_req("bus_error", 32'h1000_F018, 1'b1, 4'hF, 32'h8888_0000);
    add_req("read_r0", 32'h0000_0108, 1'b0, 4'hF, 32'h0);
    // Random mix over both regions, bad words and unmapped space
    for (int i = 0; i < RANDOM_REQS; i++) begin
      sel = rand_bits(2);
      addr = rand_bits(5) << 2;
      if (rand_bits(3) == 0) begin
        addr = addr | 32'h0000_F000;
      end
      if (sel == 2) begin
        addr = addr | `DMEM_R1_BASE;
      end else if (sel == 3) begin
        addr = addr | 32'h8000_0000;
      end
      we = rand_bits(1) != 0;
      be = 4'(rand_bits(4)) | 4'h1;
      wdata = rand_bits(32);
      add_req("random", addr, we, be, wdata);
    end
    repeat (8) @(negedge clk);
    rst_n <= 1'b1;
    // LSU stays idle for the first cycle out of reset
    @(negedge clk);
    idx = 0;
    accepted = 1'b1;
    while (accepted && idx < req_q.size()) begin
      drive_req(req_q[idx], accepted);
      idx++;
    end
    lsu_req_valid_i = 1'b0;
    cur_name = "idle";
    // Drain buffered writes and bus responses
    waited = 0;
    while ((exp_q.size() != 0 || bus_exp_q.size() != 0 || resp_q.size() != 0) &&
           waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (exp_q.size() != 0 || bus_exp_q.size() != 0 || resp_q.size() != 0) begin
      report_failure("responses or bus requests still pending at the end of the run");
    end
    finish_run();
  end

endmodule

// File: src.f
+incdir+rtl
rtl/dmem_pkg.sv
rtl/dmem_req_if.sv
rtl/dmem_pma.sv
rtl/dmem_write_buffer.sv
rtl/dmem_outstanding_fifo.sv
rtl/dmem_ctrl.sv
rtl/dmem_top.sv
dv/dmem_sva.sv
dv/dmem_tb.sv
